/* design/rename_pkg.sv */
/*
  Shared types for the register-rename unit
  Register counts are fixed constants so the lane structs have fixed widths
  Lane counts are not set here; they come from the top-level parameters
  Architectural register 0 gets no special treatment
*/
package rename_pkg;

  // ====================
  // Register counts
  // ====================
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 64;
  // Registers not covered by the reset identity map
  localparam int FREE_NUM     = PHY_REG_NUM - ARCH_REG_NUM;

  localparam int AREG_W = $clog2(ARCH_REG_NUM);
  localparam int PREG_W = $clog2(PHY_REG_NUM);

  typedef logic [AREG_W-1:0] areg_t;
  typedef logic [PREG_W-1:0] preg_t;

  // ====================
  // Lane structs
  // ====================
  // Incoming rename request, one per lane
  typedef struct packed {
    areg_t arch_rs1;
    areg_t arch_rs2;
    areg_t arch_rd;
  } rename_req_t;

  // Request plus the register taken from the free list
  typedef struct packed {
    areg_t arch_rs1;
    areg_t arch_rs2;
    areg_t arch_rd;
    preg_t new_prd;
  } alloc_lane_t;

  // Renamed output lane
  typedef struct packed {
    preg_t prs1;
    preg_t prs2;
    preg_t prd;
    preg_t old_prd;
    areg_t arch_rd;
  } renamed_lane_t;

  // Retiring instruction
  typedef struct packed {
    areg_t arch_rd;
    preg_t prd;
    preg_t old_prd;
  } commit_lane_t;

  // Content of a pipeline stage register
  typedef enum logic {
    STAGE_EMPTY = 1'b0,
    STAGE_FULL  = 1'b1
  } stage_state_e;

endpackage

/* design/free_list.sv */
/*
  Circular free list of physical registers with the stage-1 register
  Valid lanes, rename and commit alike, must be contiguous from lane 0
  Caller may rename only while alloc_ready_o is high
  Flush rewinds the speculative head to the committed head
  Flush and commit must not fall in the same cycle
*/
`timescale 1ns/1ps

module free_list #(
  parameter int RENAME_WIDTH = 2,
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     flush_i,
  input  logic [RENAME_WIDTH-1:0]                  rename_valid_i,
  input  rename_pkg::rename_req_t [RENAME_WIDTH-1:0] rename_req_i,
  input  logic [COMMIT_WIDTH-1:0]                  commit_valid_i,
  input  rename_pkg::commit_lane_t [COMMIT_WIDTH-1:0] commit_i,
  output logic                                     alloc_ready_o,
  output logic [RENAME_WIDTH-1:0]                  alloc_valid_o,
  output rename_pkg::alloc_lane_t [RENAME_WIDTH-1:0] alloc_lanes_o
);

  // Extra pointer bit tells full from empty
  localparam int PTR_W  = $clog2(rename_pkg::FREE_NUM) + 1;
  localparam int IDX_W  = PTR_W - 1;
  localparam int ACNT_W = $clog2(RENAME_WIDTH + 1);
  localparam int CCNT_W = $clog2(COMMIT_WIDTH + 1);

  rename_pkg::preg_t list_q [rename_pkg::FREE_NUM];
  logic [PTR_W-1:0]  spec_head_q;
  logic [PTR_W-1:0]  commit_head_q;
  logic [PTR_W-1:0]  tail_q;

  logic [PTR_W-1:0]        free_cnt;
  logic [RENAME_WIDTH-1:0] alloc_req;
  logic [ACNT_W-1:0]       alloc_cnt;
  logic [CCNT_W-1:0]       commit_cnt;
  logic [IDX_W-1:0]        rd_idx [RENAME_WIDTH];
  logic [IDX_W-1:0]        wr_idx [COMMIT_WIDTH];

  rename_pkg::stage_state_e                   stage_q;
  logic [RENAME_WIDTH-1:0]                    valid_q;
  rename_pkg::alloc_lane_t [RENAME_WIDTH-1:0] lanes_q;

  // ====================
  // Counts and indices
  // ====================
  always_comb begin
    // A flush drops any request in the same cycle
    alloc_req  = flush_i ? '0 : rename_valid_i;
    alloc_cnt  = ACNT_W'($countones(alloc_req));
    commit_cnt = CCNT_W'($countones(commit_valid_i));
    // Free count is head-to-tail distance
    free_cnt      = tail_q - spec_head_q;
    alloc_ready_o = free_cnt >= PTR_W'(RENAME_WIDTH);
    // Lanes are contiguous, so lane i takes entry head + i
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      rd_idx[i] = IDX_W'(spec_head_q + PTR_W'(i));
    end
    // Commit appends from the tail, wrapping
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      wr_idx[i] = IDX_W'(tail_q + PTR_W'(i));
    end
  end

  // ====================
  // List and pointers
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Registers above the identity map start free, in order
      for (int i = 0; i < rename_pkg::FREE_NUM; i++) begin
        list_q[i] <= rename_pkg::preg_t'(rename_pkg::FREE_NUM + i);
      end
      spec_head_q   <= '0;
      commit_head_q <= '0;
      tail_q        <= PTR_W'(rename_pkg::FREE_NUM);
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (commit_valid_i[i]) begin
          list_q[wr_idx[i]] <= commit_i[i].old_prd;
        end
      end
      tail_q        <= tail_q + PTR_W'(commit_cnt);
      commit_head_q <= commit_head_q + PTR_W'(commit_cnt);
      // Rewind drops all uncommitted allocations
      if (flush_i) begin
        spec_head_q <= commit_head_q;
      end else begin
        spec_head_q <= spec_head_q + PTR_W'(alloc_cnt);
      end
    end
  end

  // ====================
  // Stage-1 register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= rename_pkg::STAGE_EMPTY;
      valid_q <= '0;
    end else begin
      valid_q <= alloc_req;
      stage_q <= (|alloc_req) ? rename_pkg::STAGE_FULL : rename_pkg::STAGE_EMPTY;
    end
  end

  // Payload only, qualified by stage_q
  always_ff @(posedge clk) begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      lanes_q[i].arch_rs1 <= rename_req_i[i].arch_rs1;
      lanes_q[i].arch_rs2 <= rename_req_i[i].arch_rs2;
      lanes_q[i].arch_rd  <= rename_req_i[i].arch_rd;
      lanes_q[i].new_prd  <= list_q[rd_idx[i]];
    end
  end

  assign alloc_valid_o = (stage_q == rename_pkg::STAGE_FULL) ? valid_q : '0;
  assign alloc_lanes_o = lanes_q;

  // Source must respect ready
  a_alloc_ready: assert property (@(posedge clk) disable iff (!rst_n)
    |rename_valid_i |-> alloc_ready_o)
    else $error("free_list: rename while not ready");

  // Valid masks of the form 0..011..1
  a_lanes_contig: assert property (@(posedge clk) disable iff (!rst_n)
    ((rename_valid_i & (rename_valid_i + RENAME_WIDTH'(1))) == '0) &&
    ((commit_valid_i & (commit_valid_i + COMMIT_WIDTH'(1))) == '0))
    else $error("free_list: valid lanes not contiguous from lane 0");

  a_no_flush_commit: assert property (@(posedge clk) disable iff (!rst_n)
    !(flush_i && (|commit_valid_i)))
    else $error("free_list: flush together with commit");

endmodule

/* design/rename_map_table.sv */
/*
  Speculative and committed map tables with the stage-2 register
  Both maps reset to the identity, arch i to phys i
  Later bundles see earlier ones through the speculative map
  Within a bundle the newest earlier lane overrides the map
  Flush restores the speculative map from the committed map
*/
`timescale 1ns/1ps

module rename_map_table #(
  parameter int RENAME_WIDTH = 2,
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       flush_i,
  input  logic [RENAME_WIDTH-1:0]                    alloc_valid_i,
  input  rename_pkg::alloc_lane_t [RENAME_WIDTH-1:0]   alloc_lanes_i,
  input  logic [COMMIT_WIDTH-1:0]                    commit_valid_i,
  input  rename_pkg::commit_lane_t [COMMIT_WIDTH-1:0]  commit_i,
  output logic [RENAME_WIDTH-1:0]                    out_valid_o,
  output rename_pkg::renamed_lane_t [RENAME_WIDTH-1:0] out_lanes_o
);

  rename_pkg::preg_t spec_map_q   [rename_pkg::ARCH_REG_NUM];
  rename_pkg::preg_t commit_map_q [rename_pkg::ARCH_REG_NUM];

  rename_pkg::renamed_lane_t [RENAME_WIDTH-1:0] renamed;

  rename_pkg::stage_state_e                     out_state_q;
  logic [RENAME_WIDTH-1:0]                      out_valid_q;
  rename_pkg::renamed_lane_t [RENAME_WIDTH-1:0] out_lanes_q;

  // ====================
  // Lookup and bypass
  // ====================
  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      renamed[i].prs1    = spec_map_q[alloc_lanes_i[i].arch_rs1];
      renamed[i].prs2    = spec_map_q[alloc_lanes_i[i].arch_rs2];
      renamed[i].old_prd = spec_map_q[alloc_lanes_i[i].arch_rd];
      renamed[i].prd     = alloc_lanes_i[i].new_prd;
      renamed[i].arch_rd = alloc_lanes_i[i].arch_rd;
      // Ascending scan, so the newest earlier writer wins
      for (int j = 0; j < i; j++) begin
        if (alloc_valid_i[j]) begin
          if (alloc_lanes_i[j].arch_rd == alloc_lanes_i[i].arch_rs1) begin
            renamed[i].prs1 = alloc_lanes_i[j].new_prd;
          end
          if (alloc_lanes_i[j].arch_rd == alloc_lanes_i[i].arch_rs2) begin
            renamed[i].prs2 = alloc_lanes_i[j].new_prd;
          end
          if (alloc_lanes_i[j].arch_rd == alloc_lanes_i[i].arch_rd) begin
            renamed[i].old_prd = alloc_lanes_i[j].new_prd;
          end
        end
      end
    end
  end

  // ====================
  // Map tables
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rename_pkg::ARCH_REG_NUM; i++) begin
        spec_map_q[i] <= rename_pkg::preg_t'(i);
      end
    end else if (flush_i) begin
      // Bundle in stage 1 is dropped, never written
      spec_map_q <= commit_map_q;
    end else begin
      // Higher lane last, so it owns a shared arch_rd
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (alloc_valid_i[i]) begin
          spec_map_q[alloc_lanes_i[i].arch_rd] <= alloc_lanes_i[i].new_prd;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rename_pkg::ARCH_REG_NUM; i++) begin
        commit_map_q[i] <= rename_pkg::preg_t'(i);
      end
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (commit_valid_i[i]) begin
          commit_map_q[commit_i[i].arch_rd] <= commit_i[i].prd;
        end
      end
    end
  end

  // ====================
  // Stage-2 register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_state_q <= rename_pkg::STAGE_EMPTY;
      out_valid_q <= '0;
    end else if (flush_i) begin
      out_state_q <= rename_pkg::STAGE_EMPTY;
      out_valid_q <= '0;
    end else begin
      out_valid_q <= alloc_valid_i;
      out_state_q <= (|alloc_valid_i) ? rename_pkg::STAGE_FULL : rename_pkg::STAGE_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    out_lanes_q <= renamed;
  end

  assign out_valid_o = (out_state_q == rename_pkg::STAGE_FULL) ? out_valid_q : '0;
  assign out_lanes_o = out_lanes_q;

  // Restore copies the committed map, which must be settled
  a_no_commit_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |-> (commit_valid_i == '0))
    else $error("rename_map_table: commit lane valid during flush");

endmodule

/* design/rename_top.sv */
/*
  Register-rename unit, two stages from request to renamed bundle
  Latency is two cycles, one bundle may enter per cycle
  No back-pressure from downstream; only alloc_ready_o toward the source
*/
`timescale 1ns/1ps

module rename_top #(
  parameter int RENAME_WIDTH = 2,
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       flush_i,
  input  logic [RENAME_WIDTH-1:0]                    rename_valid_i,
  input  rename_pkg::rename_req_t [RENAME_WIDTH-1:0]   rename_req_i,
  input  logic [COMMIT_WIDTH-1:0]                    commit_valid_i,
  input  rename_pkg::commit_lane_t [COMMIT_WIDTH-1:0]  commit_i,
  output logic                                       alloc_ready_o,
  output logic [RENAME_WIDTH-1:0]                    out_valid_o,
  output rename_pkg::renamed_lane_t [RENAME_WIDTH-1:0] out_lanes_o
);

  // Stage-1 bundle, free list to map table
  logic [RENAME_WIDTH-1:0]                    alloc_valid;
  rename_pkg::alloc_lane_t [RENAME_WIDTH-1:0] alloc_lanes;

  // Stage 1, register allocation
  free_list #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) i_free_list (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .rename_valid_i (rename_valid_i),
    .rename_req_i   (rename_req_i),
    .commit_valid_i (commit_valid_i),
    .commit_i       (commit_i),
    .alloc_ready_o  (alloc_ready_o),
    .alloc_valid_o  (alloc_valid),
    .alloc_lanes_o  (alloc_lanes)
  );

  // Stage 2, map lookup and update
  rename_map_table #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) i_rename_map_table (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .alloc_valid_i  (alloc_valid),
    .alloc_lanes_i  (alloc_lanes),
    .commit_valid_i (commit_valid_i),
    .commit_i       (commit_i),
    .out_valid_o    (out_valid_o),
    .out_lanes_o    (out_lanes_o)
  );

endmodule

/* verification/tb_clock_gen.sv */
/*
  Clock and reset source for the rename testbench
  Clock period 10 ns, reset low for the first 2 rising edges
  Reset is released on a falling edge
*/
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Two full cycles of reset
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* verification/rename_tb.sv */
/*
  Testbench for the register-rename unit, default parameters (2 lanes)
  Commands come from verification/rename_testdata.txt, one per line
  Inputs change on falling edges, outputs are compared on falling edges
  Expected bundles are checked two cycles after they were driven
  Random idle gaps of 0 to 2 cycles go between commands
*/
`timescale 1ns/1ps

module rename_tb;

  localparam int RW      = 2;
  localparam int CW      = 2;
  localparam int TIMEOUT = 50;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 flush_i;
  logic [RW-1:0]                        rename_valid_i;
  rename_pkg::rename_req_t [RW-1:0]     rename_req_i;
  logic [CW-1:0]                        commit_valid_i;
  rename_pkg::commit_lane_t [CW-1:0]    commit_i;
  logic                                 alloc_ready_o;
  logic [RW-1:0]                        out_valid_o;
  rename_pkg::renamed_lane_t [RW-1:0]   out_lanes_o;

  // Expected pipeline, slot 0 is due at the current falling edge
  logic [RW-1:0]                        exp_valid [2];
  rename_pkg::renamed_lane_t [RW-1:0]   exp_lanes [2];

  int errors;
  int fd;
  bit run_ok;

  tb_clock_gen i_tb_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rename_top #(
    .RENAME_WIDTH (RW),
    .COMMIT_WIDTH (CW)
  ) i_rename_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .rename_valid_i (rename_valid_i),
    .rename_req_i   (rename_req_i),
    .commit_valid_i (commit_valid_i),
    .commit_i       (commit_i),
    .alloc_ready_o  (alloc_ready_o),
    .out_valid_o    (out_valid_o),
    .out_lanes_o    (out_lanes_o)
  );

  // ====================
  // Checks
  // ====================
  task automatic check_value(input string name, input int exp_val, input int act_val);
    assert (exp_val == act_val)
    else begin
      errors++;
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_outputs();
    check_value("out_valid_o", int'(exp_valid[0]), int'(out_valid_o));
    for (int i = 0; i < RW; i++) begin
      // Payload only matters on valid lanes
      if (exp_valid[0][i]) begin
        check_value($sformatf("out_lanes_o[%0d].prs1", i),
                    int'(exp_lanes[0][i].prs1), int'(out_lanes_o[i].prs1));
        check_value($sformatf("out_lanes_o[%0d].prs2", i),
                    int'(exp_lanes[0][i].prs2), int'(out_lanes_o[i].prs2));
        check_value($sformatf("out_lanes_o[%0d].prd", i),
                    int'(exp_lanes[0][i].prd), int'(out_lanes_o[i].prd));
        check_value($sformatf("out_lanes_o[%0d].old_prd", i),
                    int'(exp_lanes[0][i].old_prd), int'(out_lanes_o[i].old_prd));
        check_value($sformatf("out_lanes_o[%0d].arch_rd", i),
                    int'(exp_lanes[0][i].arch_rd), int'(out_lanes_o[i].arch_rd));
      end
    end
  endtask

  // One cycle: check due bundle, shift the pipe, return inputs to idle
  task automatic advance_cycle();
    @(negedge clk);
    check_outputs();
    exp_valid[0]   = exp_valid[1];
    exp_lanes[0]   = exp_lanes[1];
    exp_valid[1]   = '0;
    exp_lanes[1]   = '0;
    flush_i        = 1'b0;
    rename_valid_i = '0;
    rename_req_i   = '0;
    commit_valid_i = '0;
    commit_i       = '0;
  endtask

  // ====================
  // Command execution
  // ====================
  task automatic run_command(input byte cmd, input int f [16]);
    int k;
    advance_cycle();
    case (cmd)
      "R": begin
        check_value("alloc_ready_o", f[0], int'(alloc_ready_o));
        rename_valid_i = (f[1] == 2) ? 2'b11 : 2'b01;
        exp_valid[1]   = rename_valid_i;
        for (int i = 0; i < RW; i++) begin
          k = 2 + 7 * i;
          rename_req_i[i].arch_rs1 = rename_pkg::areg_t'(f[k]);
          rename_req_i[i].arch_rs2 = rename_pkg::areg_t'(f[k+1]);
          rename_req_i[i].arch_rd  = rename_pkg::areg_t'(f[k+2]);
          exp_lanes[1][i].arch_rd  = rename_pkg::areg_t'(f[k+2]);
          exp_lanes[1][i].prs1     = rename_pkg::preg_t'(f[k+3]);
          exp_lanes[1][i].prs2     = rename_pkg::preg_t'(f[k+4]);
          exp_lanes[1][i].prd      = rename_pkg::preg_t'(f[k+5]);
          exp_lanes[1][i].old_prd  = rename_pkg::preg_t'(f[k+6]);
        end
      end
      "C": begin
        commit_valid_i = (f[0] == 2) ? 2'b11 : 2'b01;
        for (int i = 0; i < CW; i++) begin
          k = 1 + 3 * i;
          commit_i[i].arch_rd = rename_pkg::areg_t'(f[k]);
          commit_i[i].prd     = rename_pkg::preg_t'(f[k+1]);
          commit_i[i].old_prd = rename_pkg::preg_t'(f[k+2]);
        end
      end
      "F": begin
        // Both stages empty after the flush edge
        flush_i      = 1'b1;
        exp_valid[0] = '0;
        exp_valid[1] = '0;
      end
      "I": begin
        check_value("alloc_ready_o", f[0], int'(alloc_ready_o));
      end
      default: begin
        errors++;
        $display("Unknown command '%c' in the test data file", cmd);
      end
    endcase
  endtask

  task automatic run_file();
    string line;
    byte   cmd;
    int    f [16];
    int    n_idle;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 1) continue;
      cmd = line[0];
      // Skip comments and blank lines
      if (cmd == "#" || cmd == "\n" || cmd == " ") continue;
      foreach (f[i]) f[i] = 0;
      if (line.len() > 2) begin
        void'($sscanf(line.substr(2, line.len() - 1),
          "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
          f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]));
      end
      n_idle = $urandom_range(2, 0);
      repeat (n_idle) advance_cycle();
      run_command(cmd, f);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    int cnt;
    errors         = 0;
    run_ok         = 1'b1;
    flush_i        = 1'b0;
    rename_valid_i = '0;
    rename_req_i   = '0;
    commit_valid_i = '0;
    commit_i       = '0;
    exp_valid[0]   = '0;
    exp_valid[1]   = '0;
    exp_lanes[0]   = '0;
    exp_lanes[1]   = '0;
    void'($urandom(70));

    // Wait for reset release
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      run_ok = 1'b0;
      $display("Timeout waiting for reset release");
    end

    if (run_ok) begin
      fd = $fopen("verification/rename_testdata.txt", "r");
      if (fd == 0) begin
        errors++;
        run_ok = 1'b0;
        $display("Could not open the test data file");
      end
    end

    if (run_ok) begin
      run_file();
      $fclose(fd);
      advance_cycle();
      // Drain bundles still in flight
      cnt = 0;
      while ((exp_valid[0] != '0 || exp_valid[1] != '0) && cnt < TIMEOUT) begin
        advance_cycle();
        cnt++;
      end
      if (exp_valid[0] != '0 || exp_valid[1] != '0) begin
        errors++;
        $display("Timeout while draining the expected bundles");
      end
    end

    finish_run();
  end

endmodule

/* verification/rename_testdata.txt */
# R ready n, then lane0 and lane1: rs1 rs2 rd exp_prs1 exp_prs2 exp_prd exp_old_prd
# C n, then lane0 and lane1: rd prd old_prd ; F flush ; I exp_ready
I 1
# identity map, lane 1 bypasses lane 0's destination
R 1 2 1 2 3 1 2 32 3 3 4 3 32 4 33 32
# partial bundle sees the newest map
R 1 1 3 5 6 33 5 34 6 0 0 0 0 0 0 0
R 1 2 6 3 7 34 33 35 7 7 6 8 35 34 36 8
# drain the free list, old_prd chains through the map
R 1 2 0 0 20 0 0 37 20 0 0 21 0 0 38 21
R 1 2 0 0 20 0 0 39 37 0 0 21 0 0 40 38
R 1 2 0 0 20 0 0 41 39 0 0 21 0 0 42 40
R 1 2 0 0 20 0 0 43 41 0 0 21 0 0 44 42
R 1 2 0 0 20 0 0 45 43 0 0 21 0 0 46 44
R 1 2 0 0 20 0 0 47 45 0 0 21 0 0 48 46
R 1 2 0 0 20 0 0 49 47 0 0 21 0 0 50 48
R 1 2 0 0 20 0 0 51 49 0 0 21 0 0 52 50
R 1 2 0 0 20 0 0 53 51 0 0 21 0 0 54 52
R 1 2 0 0 20 0 0 55 53 0 0 21 0 0 56 54
R 1 2 0 0 20 0 0 57 55 0 0 21 0 0 58 56
R 1 2 0 0 20 0 0 59 57 0 0 21 0 0 60 58
R 1 2 0 0 20 0 0 61 59 0 0 21 0 0 62 60
# one register left
I 0
# retire the first bundle
C 2 3 32 3 3 33 32
I 1
# wrap past 63 into the freed registers
R 1 2 1 2 9 1 2 63 9 9 20 10 63 61 3 10
I 0
C 2 6 34 6 7 35 7
I 1
# uncommitted rename, possibly still in flight at the flush
R 1 1 0 0 11 0 0 32 11 0 0 0 0 0 0 0
F
I 1
# allocation from the committed head, sources via the committed map
R 1 2 3 6 20 33 34 36 20 7 9 21 35 9 37 21
I 1

/* project.f */
design/rename_pkg.sv
design/free_list.sv
design/rename_map_table.sv
design/rename_top.sv
verification/tb_clock_gen.sv
verification/rename_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rename testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f project.f --top-module rename_tb \
  -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
